// ==== dfd_trace_sink.f ====
design/dfd_mem_pkg.sv
design/dfd_trace_pkg.sv
design/dfd_trace_stamp.sv
design/dfd_trace_mem_sink.sv
design/dfd_generic_mem.sv
design/dfd_trace_sink_top.sv
bench/dfd_trace_sink_assert.sv
bench/dfd_trace_sink_checker.sv
bench/dfd_trace_sink_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := dfd_trace_sink_tb
FLIST     := dfd_trace_sink.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/dfd_trace_sink_tb.sv ====
////////////////////
// Testbench for the trace sink, walks a stimulus table and reports the closing counts
////////////////////

`timescale 1ns/1ns

module dfd_trace_sink_tb;
  import dfd_mem_pkg::*;
  import dfd_trace_pkg::*;

  localparam int ADDR_WIDTH = 4;
  localparam int NUM_ROWS   = 12;
  // Row ops
  localparam int OP_TRACE    = 0;
  localparam int OP_IDLE     = 1;
  localparam int OP_READ     = 2;
  localparam int OP_TRACE_RD = 3;

  logic                      i_clk = 1'b0;
  logic                      i_reset_n;
  logic                      i_trace_valid;
  logic [SRC_ID_WIDTH-1:0]   i_trace_src;
  logic [PAYLOAD_WIDTH-1:0]  i_trace_payload;
  logic                      i_rd_req;
  logic [ADDR_WIDTH-1:0]     i_rd_addr;
  logic                      o_rd_valid;
  logic [ENTRY_WIDTH-1:0]    o_rd_data;
  logic [ADDR_WIDTH-1:0]     o_wr_ptr;
  logic [WRAP_CNT_WIDTH-1:0] o_wrap_cnt;
  logic [8*12-1:0]           test_name;
  int                        err_cnt;
  int                        read_cnt;

  // Stimulus table
  logic [8*12-1:0] row_name [NUM_ROWS];
  int              row_op   [NUM_ROWS];
  int              row_cnt  [NUM_ROWS];
  int              row_src  [NUM_ROWS];
  int              row_addr [NUM_ROWS];

  integer seed;
  int     cycles;
  int     limit;
  int     exp_reads;

  always #2 i_clk = ~i_clk;

  dfd_trace_sink_top #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) dfd_trace_sink_top_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_trace_valid   (i_trace_valid),
    .i_trace_src     (i_trace_src),
    .i_trace_payload (i_trace_payload),
    .i_rd_req        (i_rd_req),
    .i_rd_addr       (i_rd_addr),
    .o_rd_valid      (o_rd_valid),
    .o_rd_data       (o_rd_data),
    .o_wr_ptr        (o_wr_ptr),
    .o_wrap_cnt      (o_wrap_cnt)
  );

  dfd_trace_sink_checker #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) dfd_trace_sink_checker_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_test_name     (test_name),
    .i_trace_valid   (i_trace_valid),
    .i_trace_src     (i_trace_src),
    .i_trace_payload (i_trace_payload),
    .i_rd_req        (i_rd_req),
    .i_rd_addr       (i_rd_addr),
    .i_rd_valid      (o_rd_valid),
    .i_rd_data       (o_rd_data),
    .i_wr_ptr        (o_wr_ptr),
    .i_wrap_cnt      (o_wrap_cnt),
    .o_err_cnt       (err_cnt),
    .o_read_cnt      (read_cnt)
  );

  // Run limit from the table lengths
  always @(posedge i_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, run still busy after %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic add_row(input int idx, input logic [8*12-1:0] name, input int op,
                         input int cnt, input int src, input int addr);
    row_name[idx] = name;
    row_op[idx]   = op;
    row_cnt[idx]  = cnt;
    row_src[idx]  = src;
    row_addr[idx] = addr;
  endtask

  // Drives one strobe per cycle, optionally holding a read from the second word on
  task automatic drive_burst(input int cnt, input int src, input bit with_rd, input int addr);
    for (int i = 0; i < cnt; i++) begin
      i_trace_valid   = 1'b1;
      i_trace_src     = SRC_ID_WIDTH'(src);
      i_trace_payload = $random(seed);
      if (with_rd && i == 1) begin
        i_rd_req  = 1'b1;
        i_rd_addr = ADDR_WIDTH'(addr);
      end
      @(posedge i_clk);
      #1;
    end
    i_trace_valid = 1'b0;
  endtask

  // Holds the request until a return pulse that follows this call
  task automatic wait_read;
    do begin
      @(posedge i_clk);
      #1;
    end while (!o_rd_valid);
    i_rd_req = 1'b0;
  endtask

  initial begin
    seed            = 37;
    cycles          = 0;
    i_reset_n       = 1'b0;
    i_trace_valid   = 1'b0;
    i_trace_src     = '0;
    i_trace_payload = '0;
    i_rd_req        = 1'b0;
    i_rd_addr       = '0;
    test_name       = "reset";
    add_row(0, "single", OP_TRACE, 1, 3, 0);
    add_row(1, "idle_a", OP_IDLE, 2, 0, 0);
    add_row(2, "rd_single", OP_READ, 1, 0, 0);
    add_row(3, "burst", OP_TRACE, 8, 5, 0);
    add_row(4, "idle_b", OP_IDLE, 2, 0, 0);
    add_row(5, "rd_burst", OP_READ, 8, 0, 1);
    // 12 more words from address 9 wrap the pointer to 5
    add_row(6, "wrap", OP_TRACE, 12, 9, 0);
    add_row(7, "marker", OP_IDLE, 2, 0, 0);
    add_row(8, "rd_marker", OP_READ, 1, 0, 5);
    add_row(9, "rd_overwr", OP_READ, 5, 0, 0);
    add_row(10, "rd_in_burst", OP_TRACE_RD, 10, 11, 3);
    add_row(11, "rd_all", OP_READ, 16, 0, 0);
    limit     = 20;
    exp_reads = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      limit += (row_cnt[r] + 4) * 4;
      // One return pulse per read row entry, one per burst with a read
      if (row_op[r] == OP_READ) begin
        exp_reads += row_cnt[r];
      end else if (row_op[r] == OP_TRACE_RD) begin
        exp_reads += 1;
      end
    end
    repeat (3) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      int err_before;
      err_before = err_cnt;
      test_name  = row_name[r];
      case (row_op[r])
        OP_TRACE: drive_burst(row_cnt[r], row_src[r], 1'b0, 0);
        OP_IDLE: repeat (row_cnt[r]) begin
          @(posedge i_clk);
          #1;
        end
        OP_READ: for (int a = 0; a < row_cnt[r]; a++) begin
          i_rd_req  = 1'b1;
          i_rd_addr = ADDR_WIDTH'(row_addr[r] + a);
          wait_read();
        end
        default: begin
          drive_burst(row_cnt[r], row_src[r], 1'b1, row_addr[r]);
          wait_read();
        end
      endcase
      // Let the last pulse settle before the next row
      repeat (2) @(posedge i_clk);
      #1;
      $display("%0s: done, %0d errors", test_name, err_cnt - err_before);
    end
    $display("closing counts: %0d reads checked, %0d errors", read_cnt, err_cnt);
    if (err_cnt == 0 && read_cnt == exp_reads) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : dfd_trace_sink_tb

// ==== bench/dfd_trace_sink_checker.sv ====
////////////////////
// Reference model of the trace memory, compares host reads and status against it
////////////////////

`timescale 1ns/1ns

module dfd_trace_sink_checker import dfd_mem_pkg::*, dfd_trace_pkg::*; #(
  parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH,
  parameter int TS_WIDTH   = DEFAULT_TS_WIDTH
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic [8*12-1:0]           i_test_name,
  input  logic                      i_trace_valid,
  input  logic [SRC_ID_WIDTH-1:0]   i_trace_src,
  input  logic [PAYLOAD_WIDTH-1:0]  i_trace_payload,
  input  logic                      i_rd_req,
  input  logic [ADDR_WIDTH-1:0]     i_rd_addr,
  input  logic                      i_rd_valid,
  input  logic [ENTRY_WIDTH-1:0]    i_rd_data,
  input  logic [ADDR_WIDTH-1:0]     i_wr_ptr,
  input  logic [WRAP_CNT_WIDTH-1:0] i_wrap_cnt,
  output int                        o_err_cnt,
  output int                        o_read_cnt
);

  // Model state
  logic [ENTRY_WIDTH-1:0]    model_mem [1 << ADDR_WIDTH];
  logic [TS_WIDTH-1:0]       ts;
  logic                      st_valid;
  trace_entry_u              st_entry;
  logic [ADDR_WIDTH-1:0]     ptr;
  logic [WRAP_CNT_WIDTH-1:0] wraps;
  logic                      pend;
  logic                      prev_req;
  // Address held with the request one edge before the pulse
  logic [ADDR_WIDTH-1:0]     prev_addr;

  initial begin
    o_err_cnt  = 0;
    o_read_cnt = 0;
  end

  // Samples before the DUT registers update, so all values are the pre-edge ones
  always @(posedge i_clk) begin
    trace_entry_u wr;
    logic         do_wr;
    if (!i_reset_n) begin
      ts        = '0;
      st_valid  = 1'b0;
      ptr       = '0;
      wraps     = '0;
      pend      = 1'b0;
      prev_req  = 1'b0;
      prev_addr = '0;
    end else begin
      if (i_rd_valid) begin
        o_read_cnt++;
        if (!prev_req) begin
          $display("%0s: read valid pulse with no request pending", i_test_name);
          o_err_cnt++;
        end else if (i_rd_data !== model_mem[prev_addr]) begin
          $display("mismatch %0s: addr %0d expected %h actual %h", i_test_name,
                   prev_addr, model_mem[prev_addr], i_rd_data);
          o_err_cnt++;
        end
      end
      if (i_wr_ptr !== ptr || i_wrap_cnt !== wraps) begin
        $display("mismatch %0s: ptr/wraps expected %0d/%0d actual %0d/%0d",
                 i_test_name, ptr, wraps, i_wr_ptr, i_wrap_cnt);
        o_err_cnt++;
      end
      // Data first, then a pending marker
      do_wr = 1'b0;
      wr    = '0;
      if (st_valid) begin
        wr    = st_entry;
        do_wr = 1'b1;
      end else if (pend) begin
        wr.marker.kind     = KIND_MARKER;
        wr.marker.ts       = DEFAULT_TS_WIDTH'(ts);
        wr.marker.wrap_cnt = wraps;
        do_wr              = 1'b1;
        pend               = 1'b0;
      end
      if (do_wr) begin
        model_mem[ptr] = wr;
        if (ptr == '1) begin
          wraps++;
          pend = 1'b1;
        end
        ptr++;
      end
      // Input register of the stamp stage
      st_valid = i_trace_valid;
      if (i_trace_valid) begin
        st_entry.data.kind    = KIND_DATA;
        st_entry.data.src     = i_trace_src;
        st_entry.data.ts      = DEFAULT_TS_WIDTH'(ts);
        st_entry.data.payload = i_trace_payload;
      end
      ts++;
      prev_req  = i_rd_req;
      prev_addr = i_rd_addr;
    end
  end

endmodule : dfd_trace_sink_checker

// ==== bench/dfd_trace_sink_assert.sv ====
////////////////////
// Protocol assertions on the trace writer, bound into dfd_trace_mem_sink
////////////////////

`timescale 1ns/1ns

module dfd_trace_sink_assert (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_mem_chip_en,
  input logic i_mem_wr_en,
  input logic i_rd_valid
);

  // RAM write only while the chip is enabled
  a_wr_needs_ce : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_wr_en |-> i_mem_chip_en)
    else $error("memory write enable high without chip enable");

  // One return pulse per request
  a_rd_valid_pulse : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_rd_valid |=> !i_rd_valid)
    else $error("read valid high for two cycles in a row");

  // A write cycle on the port never has a host read returning after it
  a_no_rd_on_wr : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_wr_en |=> !i_rd_valid)
    else $error("host read issued in a write cycle");

endmodule : dfd_trace_sink_assert

bind dfd_trace_mem_sink dfd_trace_sink_assert dfd_trace_sink_assert_i (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_mem_chip_en (o_mem_chip_en),
  .i_mem_wr_en   (o_mem_wr_en),
  .i_rd_valid    (o_rd_valid)
);

// ==== design/dfd_trace_sink_top.sv ====
////////////////////
// Trace sink top level, chains stamp, writer and trace RAM
////////////////////

`timescale 1ns/1ns

module dfd_trace_sink_top import dfd_mem_pkg::*, dfd_trace_pkg::*; #(
  parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH,
  parameter int TS_WIDTH   = DEFAULT_TS_WIDTH
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // Trace source, plain strobe with no back-pressure
  input  logic                      i_trace_valid,
  input  logic [SRC_ID_WIDTH-1:0]   i_trace_src,
  input  logic [PAYLOAD_WIDTH-1:0]  i_trace_payload,
  // Host read
  input  logic                      i_rd_req,
  input  logic [ADDR_WIDTH-1:0]     i_rd_addr,
  output logic                      o_rd_valid,
  output logic [ENTRY_WIDTH-1:0]    o_rd_data,
  // Status
  output logic [ADDR_WIDTH-1:0]     o_wr_ptr,
  output logic [WRAP_CNT_WIDTH-1:0] o_wrap_cnt
);

  // Stamp to sink
  logic                   stamp_valid;
  trace_entry_u           stamp_entry;
  logic [TS_WIDTH-1:0]    stamp_ts;
  // Sink to RAM and back
  logic                   mem_chip_en;
  logic                   mem_wr_en;
  logic [ADDR_WIDTH-1:0]  mem_addr;
  logic [ENTRY_WIDTH-1:0] mem_wr_data;
  logic [ENTRY_WIDTH-1:0] mem_rd_data;

  dfd_trace_stamp #(
    .TS_WIDTH (TS_WIDTH)
  ) dfd_trace_stamp_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_trace_valid   (i_trace_valid),
    .i_trace_src     (i_trace_src),
    .i_trace_payload (i_trace_payload),
    .o_valid         (stamp_valid),
    .o_entry         (stamp_entry),
    .o_ts            (stamp_ts)
  );

  dfd_trace_mem_sink #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .TS_WIDTH   (TS_WIDTH)
  ) dfd_trace_mem_sink_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_valid       (stamp_valid),
    .i_entry       (stamp_entry),
    .i_ts          (stamp_ts),
    .i_rd_req      (i_rd_req),
    .i_rd_addr     (i_rd_addr),
    .i_mem_rd_data (mem_rd_data),
    .o_mem_chip_en (mem_chip_en),
    .o_mem_wr_en   (mem_wr_en),
    .o_mem_addr    (mem_addr),
    .o_mem_wr_data (mem_wr_data),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data),
    .o_wr_ptr      (o_wr_ptr),
    .o_wrap_cnt    (o_wrap_cnt)
  );

  dfd_generic_mem #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (ENTRY_WIDTH)
  ) dfd_generic_mem_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_mem_chip_en (mem_chip_en),
    .i_mem_wr_en   (mem_wr_en),
    .i_mem_addr    (mem_addr),
    .i_mem_wr_data (mem_wr_data),
    .o_mem_rd_data (mem_rd_data)
  );

endmodule : dfd_trace_sink_top

// ==== design/dfd_generic_mem.sv ====
////////////////////
// Single-port RAM model with a registered read, one cycle of latency
////////////////////

`timescale 1ns/1ns

module dfd_generic_mem import dfd_mem_pkg::*; #(
  parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH,
  parameter int DATA_WIDTH = ENTRY_WIDTH
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_mem_chip_en,
  input  logic                  i_mem_wr_en,
  input  logic [ADDR_WIDTH-1:0] i_mem_addr,
  input  logic [DATA_WIDTH-1:0] i_mem_wr_data,
  output logic [DATA_WIDTH-1:0] o_mem_rd_data
);

  localparam int NumRows = 1 << ADDR_WIDTH;

  // Storage, contents survive reset
  logic [DATA_WIDTH-1:0] mem_data [NumRows];

  // Whole-word write at the edge
  always_ff @(posedge i_clk) begin
    if (i_mem_chip_en && i_mem_wr_en) begin
      mem_data[i_mem_addr] <= i_mem_wr_data;
    end
  end

  // Read only in cycles without a write
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      o_mem_rd_data <= '0;
    end else if (i_mem_chip_en && !i_mem_wr_en) begin
      o_mem_rd_data <= mem_data[i_mem_addr];
    end
  end

endmodule : dfd_generic_mem

// ==== design/dfd_trace_mem_sink.sv ====
////////////////////
// Circular trace writer with wrap markers, host reads share the single RAM port
////////////////////

`timescale 1ns/1ns

module dfd_trace_mem_sink import dfd_mem_pkg::*, dfd_trace_pkg::*; #(
  parameter int ADDR_WIDTH = DEFAULT_ADDR_WIDTH,
  parameter int TS_WIDTH   = DEFAULT_TS_WIDTH
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  // Stamped entries from the first stage
  input  logic                      i_valid,
  input  trace_entry_u              i_entry,
  input  logic [TS_WIDTH-1:0]       i_ts,
  // Host read, request held until o_rd_valid
  input  logic                      i_rd_req,
  input  logic [ADDR_WIDTH-1:0]     i_rd_addr,
  // Single RW port of the trace RAM
  input  logic [ENTRY_WIDTH-1:0]    i_mem_rd_data,
  output logic                      o_mem_chip_en,
  output logic                      o_mem_wr_en,
  output logic [ADDR_WIDTH-1:0]     o_mem_addr,
  output logic [ENTRY_WIDTH-1:0]    o_mem_wr_data,
  // Host read return
  output logic                      o_rd_valid,
  output logic [ENTRY_WIDTH-1:0]    o_rd_data,
  // Status
  output logic [ADDR_WIDTH-1:0]     o_wr_ptr,
  output logic [WRAP_CNT_WIDTH-1:0] o_wrap_cnt
);

  // Set by a pointer wrap, cleared once the marker is stored
  logic         marker_pending;
  logic         marker_wr;
  logic         wr_cycle;
  logic         rd_issue;
  logic         ptr_wrap;
  trace_entry_u marker_entry;
  trace_entry_u wr_entry;

  // Port priority is data, then marker, then host read
  assign marker_wr = marker_pending && !i_valid;
  assign wr_cycle  = i_valid || marker_wr;
  // No reissue while the previous read is still returning
  assign rd_issue  = i_rd_req && !wr_cycle && !o_rd_valid;
  assign ptr_wrap  = wr_cycle && (o_wr_ptr == '1);

  // Marker carries the live timestamp and the already bumped wrap count
  always_comb begin
    marker_entry                 = '0;
    marker_entry.marker.kind     = KIND_MARKER;
    marker_entry.marker.ts       = DEFAULT_TS_WIDTH'(i_ts);
    marker_entry.marker.wrap_cnt = o_wrap_cnt;
  end

  assign wr_entry = i_valid ? i_entry : marker_entry;

  // Writes go to the pointer, reads to the host address
  assign o_mem_chip_en = wr_cycle || rd_issue;
  assign o_mem_wr_en   = wr_cycle;
  assign o_mem_addr    = wr_cycle ? o_wr_ptr : i_rd_addr;
  assign o_mem_wr_data = wr_entry;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      o_wr_ptr       <= '0;
      o_wrap_cnt     <= '0;
      marker_pending <= 1'b0;
      o_rd_valid     <= 1'b0;
    end else begin
      // RAM read is registered, so the pulse follows the issue by one cycle
      o_rd_valid <= rd_issue;
      if (wr_cycle) begin
        o_wr_ptr <= o_wr_ptr + 1'b1;
      end
      if (marker_wr) begin
        marker_pending <= 1'b0;
      end
      // A wrap wins over clearing, even when the marker itself wraps
      if (ptr_wrap) begin
        o_wrap_cnt     <= o_wrap_cnt + 1'b1;
        marker_pending <= 1'b1;
      end
    end
  end

  // Read data is only meaningful with o_rd_valid
  assign o_rd_data = i_mem_rd_data;

endmodule : dfd_trace_mem_sink

// ==== design/dfd_trace_stamp.sv ====
////////////////////
// First trace stage, registers the input strobe and stamps it with the cycle count
////////////////////

`timescale 1ns/1ns

module dfd_trace_stamp import dfd_trace_pkg::*; #(
  parameter int TS_WIDTH = DEFAULT_TS_WIDTH
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_trace_valid,
  input  logic [SRC_ID_WIDTH-1:0]  i_trace_src,
  input  logic [PAYLOAD_WIDTH-1:0] i_trace_payload,
  output logic                     o_valid,
  output trace_entry_u             o_entry,
  output logic [TS_WIDTH-1:0]      o_ts
);

  // Free-running timestamp, zero in the first cycle out of reset
  logic [TS_WIDTH-1:0] ts_cnt;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      ts_cnt  <= '0;
      o_valid <= 1'b0;
    end else begin
      // Wraps silently at TS_WIDTH
      ts_cnt  <= ts_cnt + 1'b1;
      o_valid <= i_trace_valid;
    end
  end

  // Entry payload only loads on a strobe
  always_ff @(posedge i_clk) begin
    if (i_trace_valid) begin
      o_entry.data.kind    <= KIND_DATA;
      o_entry.data.src     <= i_trace_src;
      // Count of the cycle the strobe was sampled in
      o_entry.data.ts      <= DEFAULT_TS_WIDTH'(ts_cnt);
      o_entry.data.payload <= i_trace_payload;
    end
  end

  // Live count, the sink stamps wrap markers with it
  assign o_ts = ts_cnt;

endmodule : dfd_trace_stamp

// ==== design/dfd_trace_pkg.sv ====
////////////////////
// Trace entry fields and the two views of a stored trace word
////////////////////

package dfd_trace_pkg;

  // Field widths of a trace entry
  localparam int DEFAULT_TS_WIDTH = 24;
  localparam int SRC_ID_WIDTH     = 7;
  localparam int PAYLOAD_WIDTH    = 32;
  localparam int WRAP_CNT_WIDTH   = 32;

  // Top bit of every entry tells the two views apart
  typedef enum logic {
    KIND_DATA   = 1'b0,
    KIND_MARKER = 1'b1
  } trace_kind_e;

  // Word captured from the debug source
  typedef struct packed {
    trace_kind_e                 kind;
    logic [SRC_ID_WIDTH-1:0]     src;
    logic [DEFAULT_TS_WIDTH-1:0] ts;
    logic [PAYLOAD_WIDTH-1:0]    payload;
  } trace_data_t;

  // Word inserted by the sink after the write pointer wraps
  typedef struct packed {
    trace_kind_e                 kind;
    // Sits where the source id is, always zero
    logic [SRC_ID_WIDTH-1:0]     rsvd;
    logic [DEFAULT_TS_WIDTH-1:0] ts;
    logic [WRAP_CNT_WIDTH-1:0]   wrap_cnt;
  } trace_marker_t;

  typedef union packed {
    trace_data_t   data;
    trace_marker_t marker;
  } trace_entry_u;

endpackage : dfd_trace_pkg

// ==== design/dfd_mem_pkg.sv ====
////////////////////
// Trace memory geometry, shared by the sink, the RAM model and the top level
////////////////////

package dfd_mem_pkg;

  // One trace entry per memory word
  localparam int ENTRY_WIDTH = 64;

  // 512 entries unless the top level picks another depth
  localparam int DEFAULT_ADDR_WIDTH = 9;

endpackage : dfd_mem_pkg
